//--- source/l2_geom_pkg.sv
`default_nettype none

package l2_geom_pkg;

    // address split into tag, index, word offset and byte offset
    localparam int addr_width   = 32;
    localparam int index_width  = 2;
    localparam int offset_width = 3;
    localparam int tag_width    = addr_width - index_width - offset_width - 2;

    // array geometry
    localparam int way_count = 4;
    localparam int set_count = 1 << index_width;
    localparam int line_bits = 32 << offset_width;

    // half line handed back to a first-level cache
    localparam int half_bits = line_bits / 2;

endpackage

`default_nettype wire

//--- source/l2_ctrl_pkg.sv
`default_nettype none

package l2_ctrl_pkg;

    typedef enum logic [2:0] {
        idle,
        lookup,
        respond,
        writeback,
        refill_req,
        refill_wait,
        fill
    } l2_state_t;

    // icache maps to ways 0 and 1, data sources to ways 2 and 3
    typedef enum logic [1:0] {
        src_icache,
        src_dread,
        src_dwrite
    } l2_src_t;

endpackage

`default_nettype wire

//--- source/l2_req_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module l2_req_buffer
    import l2_geom_pkg::*;
    import l2_ctrl_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   icache_req,
    input  wire  [addr_width-1:0] icache_addr,
    input  wire                   dcache_req,
    input  wire                   dcache_wr,
    input  wire  [addr_width-1:0] dcache_addr,
    input  wire  [31:0]           dcache_wdata,
    input  wire  [3:0]            dcache_wstrb,
    input  wire                   accept,
    output l2_src_t               grant_src,
    output logic                  pending,
    output logic                  icache_addr_ok,
    output logic                  dcache_addr_ok,
    output l2_src_t               buf_src,
    output logic [addr_width-1:0] buf_addr,
    output logic [31:0]           buf_wdata,
    output logic [3:0]            buf_wstrb
);

    // dcache has priority
    always_comb begin
        if (dcache_req) begin
            grant_src = dcache_wr ? src_dwrite : src_dread;
        end else begin
            grant_src = src_icache;
        end
    end

    assign pending        = icache_req || dcache_req;
    assign icache_addr_ok = accept && (grant_src == src_icache);
    assign dcache_addr_ok = accept && (grant_src != src_icache);

    always_ff @(posedge clk) begin
        if (rst) begin
            buf_src <= src_icache;
        end else if (accept) begin
            buf_src <= grant_src;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            buf_addr  <= (grant_src == src_icache) ? icache_addr : dcache_addr;
            buf_wdata <= dcache_wdata;
            buf_wstrb <= dcache_wstrb;
        end
    end

endmodule

`default_nettype wire

//--- source/l2_tag_array.sv
`timescale 1ns/10ps
`default_nettype none

module l2_tag_array
    import l2_geom_pkg::*;
    import l2_ctrl_pkg::*;
(
    input  wire                          clk,
    input  wire                          rst,
    input  wire  [index_width-1:0]       index,
    input  wire  [tag_width-1:0]         tag,
    input  wire  l2_src_t                buf_src,
    output logic [1:0]                   hit_way,
    output logic                         hit,
    output logic [way_count-1:0]         way_valid,
    output logic [tag_width-1:0]         victim_tag,
    output logic                         victim_dirty,
    input  wire  [$clog2(way_count)-1:0] fill_way,
    input  wire                          fill_we,
    input  wire                          set_dirty_we
);

    logic [tag_width-1:0] tags  [set_count][way_count];
    logic [way_count-1:0] valid [set_count];
    logic [way_count-1:0] dirty [set_count];

    logic part;
    logic match0;
    logic match1;

    // only the two ways of the requester's partition take part
    assign part   = (buf_src != src_icache);
    assign match0 = valid[index][{part, 1'b0}] && (tags[index][{part, 1'b0}] == tag);
    assign match1 = valid[index][{part, 1'b1}] && (tags[index][{part, 1'b1}] == tag);

    assign hit       = match0 || match1;
    assign hit_way   = {part, match1};
    assign way_valid = valid[index];

    // way under fill or writeback
    assign victim_tag   = tags[index][fill_way];
    assign victim_dirty = valid[index][fill_way] && dirty[index][fill_way];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < set_count; s++) begin
                valid[s] <= '0;
                dirty[s] <= '0;
                for (int w = 0; w < way_count; w++) begin
                    tags[s][w] <= '0;
                end
            end
        end else if (fill_we) begin
            tags[index][fill_way]  <= tag;
            valid[index][fill_way] <= 1'b1;
            dirty[index][fill_way] <= 1'b0;
        end else if (set_dirty_we) begin
            dirty[index][fill_way] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- source/l2_data_array.sv
`timescale 1ns/10ps
`default_nettype none

module l2_data_array
    import l2_geom_pkg::*;
(
    input  wire                          clk,
    input  wire  [index_width-1:0]       index,
    input  wire  [offset_width-1:0]      word_off,
    input  wire  [$clog2(way_count)-1:0] way_sel,
    input  wire  [line_bits-1:0]         line_in,
    input  wire  [31:0]                  word_in,
    input  wire  [3:0]                   wstrb,
    input  wire                          line_we,
    input  wire                          word_we,
    output logic [line_bits-1:0]         line_out
);

    localparam int slot_bits = index_width + $clog2(way_count);

    logic [line_bits-1:0] lines [set_count * way_count];
    logic [slot_bits-1:0] slot;

    // one flat slot per set and way
    assign slot = {index, way_sel};

    always_ff @(posedge clk) begin
        if (line_we) begin
            lines[slot] <= line_in;
        end else if (word_we) begin
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) begin
                    lines[slot][word_off * 32 + b * 8 +: 8] <= word_in[b * 8 +: 8];
                end
            end
        end
    end

    assign line_out = lines[slot];

endmodule

`default_nettype wire

//--- source/l2_victim_lru.sv
`timescale 1ns/10ps
`default_nettype none

module l2_victim_lru
    import l2_geom_pkg::*;
    import l2_ctrl_pkg::*;
(
    input  wire                          clk,
    input  wire                          rst,
    input  wire  [index_width-1:0]       index,
    input  wire  l2_src_t                buf_src,
    input  wire                          touch,
    input  wire  [$clog2(way_count)-1:0] touch_way,
    input  wire  [way_count-1:0]         way_valid,
    output logic [$clog2(way_count)-1:0] victim_way
);

    // bit per partition names the older way of the pair
    logic [1:0] lru [set_count];
    logic       part;

    assign part = (buf_src != src_icache);

    always_comb begin
        if (!way_valid[{part, 1'b0}]) begin
            victim_way = {part, 1'b0};
        end else if (!way_valid[{part, 1'b1}]) begin
            victim_way = {part, 1'b1};
        end else begin
            victim_way = {part, lru[index][part]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < set_count; s++) begin
                lru[s] <= '0;
            end
        end else if (touch) begin
            lru[index][touch_way[1]] <= ~touch_way[0];
        end
    end

endmodule

`default_nettype wire

//--- source/l2_controller.sv
`timescale 1ns/10ps
`default_nettype none

module l2_controller
    import l2_geom_pkg::*;
    import l2_ctrl_pkg::*;
(
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          pending,
    input  wire  l2_src_t                buf_src,
    input  wire                          hit,
    input  wire  [$clog2(way_count)-1:0] hit_way,
    input  wire  [$clog2(way_count)-1:0] victim_way,
    input  wire                          victim_dirty,
    input  wire                          mem_rd_addr_ok,
    input  wire                          mem_rd_data_ok,
    input  wire                          mem_wr_addr_ok,
    output logic                         accept,
    output logic                         fill_we,
    output logic                         set_dirty_we,
    output logic                         word_we,
    output logic                         line_we,
    output logic                         touch,
    output logic [$clog2(way_count)-1:0] way_sel,
    output logic                         icache_data_ok,
    output logic                         dcache_data_ok,
    output logic                         mem_rd_req,
    output logic                         mem_wr_req
);

    l2_state_t                    state;
    l2_state_t                    state_next;
    logic [$clog2(way_count)-1:0] sel_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            sel_q <= '0;
        end else begin
            state <= state_next;
            // hit way or the victim on a miss
            if (state == lookup) begin
                sel_q <= hit ? hit_way : victim_way;
            end
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            idle: begin
                if (pending) begin
                    state_next = lookup;
                end
            end
            lookup: begin
                if (hit) begin
                    state_next = respond;
                end else if (victim_dirty) begin
                    state_next = writeback;
                end else begin
                    state_next = refill_req;
                end
            end
            respond: begin
                state_next = idle;
            end
            writeback: begin
                if (mem_wr_addr_ok) begin
                    state_next = refill_req;
                end
            end
            refill_req: begin
                if (mem_rd_addr_ok) begin
                    state_next = refill_wait;
                end
            end
            refill_wait: begin
                if (mem_rd_data_ok) begin
                    state_next = fill;
                end
            end
            // tag goes valid here so the replayed lookup hits
            fill: begin
                state_next = lookup;
            end
            default: begin
                state_next = idle;
            end
        endcase
    end

    assign accept  = (state == idle) && pending;
    assign way_sel = (state == lookup) ? (hit ? hit_way : victim_way) : sel_q;

    assign touch        = (state == respond);
    assign word_we      = (state == respond) && (buf_src == src_dwrite);
    assign set_dirty_we = word_we;

    // refill line is only valid in the data_ok cycle
    assign line_we = (state == refill_wait) && mem_rd_data_ok;
    assign fill_we = (state == fill);

    assign icache_data_ok = (state == respond) && (buf_src == src_icache);
    assign dcache_data_ok = (state == respond) && (buf_src != src_icache);

    assign mem_wr_req = (state == writeback);
    assign mem_rd_req = (state == refill_req);

endmodule

`default_nettype wire

//--- source/l2_cache.sv
`timescale 1ns/10ps
`default_nettype none

module l2_cache
    import l2_geom_pkg::*;
    import l2_ctrl_pkg::*;
(
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   icache_req,
    input  wire  [addr_width-1:0] icache_addr,
    output logic                  icache_addr_ok,
    output logic                  icache_data_ok,
    output logic [half_bits-1:0]  icache_rdata,
    input  wire                   dcache_req,
    input  wire                   dcache_wr,
    input  wire  [addr_width-1:0] dcache_addr,
    input  wire  [31:0]           dcache_wdata,
    input  wire  [3:0]            dcache_wstrb,
    output logic                  dcache_addr_ok,
    output logic                  dcache_data_ok,
    output logic [half_bits-1:0]  dcache_rdata,
    output logic                  mem_rd_req,
    output logic [addr_width-1:0] mem_rd_addr,
    input  wire                   mem_rd_addr_ok,
    input  wire  [line_bits-1:0]  mem_rd_data,
    input  wire                   mem_rd_data_ok,
    output logic                  mem_wr_req,
    output logic [addr_width-1:0] mem_wr_addr,
    output logic [line_bits-1:0]  mem_wr_data,
    input  wire                   mem_wr_addr_ok
);

    l2_src_t                      buf_src;
    logic                         pending;
    logic                         accept;
    logic [addr_width-1:0]        buf_addr;
    logic [31:0]                  buf_wdata;
    logic [3:0]                   buf_wstrb;
    logic [tag_width-1:0]         buf_tag;
    logic [index_width-1:0]       buf_index;
    logic [offset_width-1:0]      word_off;
    logic                         hit;
    logic [1:0]                   hit_way;
    logic [way_count-1:0]         way_valid;
    logic [tag_width-1:0]         victim_tag;
    logic                         victim_dirty;
    logic [$clog2(way_count)-1:0] victim_way;
    logic [$clog2(way_count)-1:0] way_sel;
    logic                         fill_we;
    logic                         set_dirty_we;
    logic                         word_we;
    logic                         line_we;
    logic                         touch;
    logic [line_bits-1:0]         line_out;
    logic [half_bits-1:0]         half;

    assign buf_tag   = buf_addr[addr_width-1 -: tag_width];
    assign buf_index = buf_addr[offset_width + 2 +: index_width];
    assign word_off  = buf_addr[offset_width + 1:2];

    l2_req_buffer u_req_buffer (
        .clk            (clk),
        .rst            (rst),
        .icache_req     (icache_req),
        .icache_addr    (icache_addr),
        .dcache_req     (dcache_req),
        .dcache_wr      (dcache_wr),
        .dcache_addr    (dcache_addr),
        .dcache_wdata   (dcache_wdata),
        .dcache_wstrb   (dcache_wstrb),
        .accept         (accept),
        .grant_src      (),
        .pending        (pending),
        .icache_addr_ok (icache_addr_ok),
        .dcache_addr_ok (dcache_addr_ok),
        .buf_src        (buf_src),
        .buf_addr       (buf_addr),
        .buf_wdata      (buf_wdata),
        .buf_wstrb      (buf_wstrb)
    );

    l2_tag_array u_tag_array (
        .clk          (clk),
        .rst          (rst),
        .index        (buf_index),
        .tag          (buf_tag),
        .buf_src      (buf_src),
        .hit_way      (hit_way),
        .hit          (hit),
        .way_valid    (way_valid),
        .victim_tag   (victim_tag),
        .victim_dirty (victim_dirty),
        .fill_way     (way_sel),
        .fill_we      (fill_we),
        .set_dirty_we (set_dirty_we)
    );

    l2_data_array u_data_array (
        .clk      (clk),
        .index    (buf_index),
        .word_off (word_off),
        .way_sel  (way_sel),
        .line_in  (mem_rd_data),
        .word_in  (buf_wdata),
        .wstrb    (buf_wstrb),
        .line_we  (line_we),
        .word_we  (word_we),
        .line_out (line_out)
    );

    l2_victim_lru u_victim_lru (
        .clk        (clk),
        .rst        (rst),
        .index      (buf_index),
        .buf_src    (buf_src),
        .touch      (touch),
        .touch_way  (way_sel),
        .way_valid  (way_valid),
        .victim_way (victim_way)
    );

    l2_controller u_controller (
        .clk            (clk),
        .rst            (rst),
        .pending        (pending),
        .buf_src        (buf_src),
        .hit            (hit),
        .hit_way        (hit_way),
        .victim_way     (victim_way),
        .victim_dirty   (victim_dirty),
        .mem_rd_addr_ok (mem_rd_addr_ok),
        .mem_rd_data_ok (mem_rd_data_ok),
        .mem_wr_addr_ok (mem_wr_addr_ok),
        .accept         (accept),
        .fill_we        (fill_we),
        .set_dirty_we   (set_dirty_we),
        .word_we        (word_we),
        .line_we        (line_we),
        .touch          (touch),
        .way_sel        (way_sel),
        .icache_data_ok (icache_data_ok),
        .dcache_data_ok (dcache_data_ok),
        .mem_rd_req     (mem_rd_req),
        .mem_wr_req     (mem_wr_req)
    );

    // line aligned memory addresses
    assign mem_rd_addr = {buf_tag, buf_index, {(offset_width + 2){1'b0}}};
    assign mem_wr_addr = {victim_tag, buf_index, {(offset_width + 2){1'b0}}};
    assign mem_wr_data = line_out;

    // upper or lower half by word offset bit 2
    assign half = word_off[offset_width-1] ? line_out[line_bits-1 -: half_bits]
                                           : line_out[half_bits-1:0];

    assign icache_rdata = half;
    assign dcache_rdata = half;

endmodule

`default_nettype wire

//--- test/l2_cache_checker.sv
`timescale 1ns/10ps
`default_nettype none

module l2_cache_checker (
    input wire clk,
    input wire rst,
    input wire icache_addr_ok,
    input wire dcache_addr_ok,
    input wire icache_data_ok,
    input wire dcache_data_ok,
    input wire mem_rd_req,
    input wire mem_rd_addr_ok,
    input wire mem_wr_req,
    input wire mem_wr_addr_ok
);

    int   fail_count = 0;
    logic i_open;
    logic d_open;

    // one open request per client between addr_ok and data_ok
    always_ff @(posedge clk) begin
        if (rst) begin
            i_open <= 1'b0;
            d_open <= 1'b0;
        end else begin
            if (icache_addr_ok) begin
                i_open <= 1'b1;
            end else if (icache_data_ok) begin
                i_open <= 1'b0;
            end
            if (dcache_addr_ok) begin
                d_open <= 1'b1;
            end else if (dcache_data_ok) begin
                d_open <= 1'b0;
            end
        end
    end

    addr_ok_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(icache_addr_ok && dcache_addr_ok))
    else begin
        $error("icache_addr_ok and dcache_addr_ok high together");
        fail_count++;
    end

    rd_req_held: assert property (@(posedge clk) disable iff (rst)
        mem_rd_req && !mem_rd_addr_ok |=> mem_rd_req)
    else begin
        $error("mem_rd_req dropped before mem_rd_addr_ok");
        fail_count++;
    end

    wr_req_held: assert property (@(posedge clk) disable iff (rst)
        mem_wr_req && !mem_wr_addr_ok |=> mem_wr_req)
    else begin
        $error("mem_wr_req dropped before mem_wr_addr_ok");
        fail_count++;
    end

    data_ok_owned: assert property (@(posedge clk) disable iff (rst)
        (!icache_data_ok || i_open) && (!dcache_data_ok || d_open))
    else begin
        $error("data_ok without an outstanding request");
        fail_count++;
    end

    quiet_after_reset: assert property (@(posedge clk)
        rst |=> !(icache_addr_ok || dcache_addr_ok || icache_data_ok || dcache_data_ok
                  || mem_rd_req || mem_wr_req))
    else begin
        $error("handshake output high in the cycle after reset");
        fail_count++;
    end

endmodule

`default_nettype wire

//--- test/l2_cache_tb.sv
`timescale 1ns/10ps
`default_nettype none

module l2_cache_tb
    import l2_geom_pkg::*;
();

    // icache and dcache traffic kept in separate regions
    localparam logic [31:0] ibase = 32'h0010_0000;
    localparam logic [31:0] dbase = 32'h0020_0000;
    // about 80 random ops at under 30 cycles each, plus the directed tests
    localparam int cycle_limit = 4000;

    logic                  clk;
    logic                  rst;
    logic                  icache_req;
    logic [addr_width-1:0] icache_addr;
    logic                  icache_addr_ok;
    logic                  icache_data_ok;
    logic [half_bits-1:0]  icache_rdata;
    logic                  dcache_req;
    logic                  dcache_wr;
    logic [addr_width-1:0] dcache_addr;
    logic [31:0]           dcache_wdata;
    logic [3:0]            dcache_wstrb;
    logic                  dcache_addr_ok;
    logic                  dcache_data_ok;
    logic [half_bits-1:0]  dcache_rdata;
    logic                  mem_rd_req;
    logic [addr_width-1:0] mem_rd_addr;
    logic                  mem_rd_addr_ok;
    logic [line_bits-1:0]  mem_rd_data;
    logic                  mem_rd_data_ok;
    logic                  mem_wr_req;
    logic [addr_width-1:0] mem_wr_addr;
    logic [line_bits-1:0]  mem_wr_data;
    logic                  mem_wr_addr_ok;

    logic [31:0]           model_words [logic [31:0]];
    logic [line_bits-1:0]  mem_lines [logic [31:0]];
    logic [half_bits-1:0]  exp_ihalf;
    logic [half_bits-1:0]  exp_dhalf;
    logic                  d_write;
    logic [addr_width-1:0] cur_addr;
    logic [addr_width-1:0] last_wr_addr;
    int                    wr_count = 0;
    int                    i_sent = 0;
    int                    i_done = 0;
    int                    d_sent = 0;
    int                    d_done = 0;
    int                    i_acc_cycle;
    int                    i_done_cycle;
    int                    d_acc_cycle;
    int                    d_done_cycle;
    int                    cycle = 0;
    int                    checks = 0;
    int                    errors = 0;
    int                    test_no = 1;
    int                    test_errors = 0;

    l2_cache DUT (.*);

    bind l2_cache l2_cache_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #4;
            clk = ~clk;
        end
    end

    always @(negedge clk) begin
        cycle <= cycle + 1;
    end

    initial begin : watchdog
        wait (cycle >= cycle_limit);
        $display("timeout after %0d cycles, a request never completed", cycle);
        $display("Checks failed");
        $finish;
    end

    // backing memory content before any writeback
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5bd1_e995;
    endfunction

    // reference model of the data side view of memory
    function automatic logic [31:0] ref_word(input logic [31:0] addr);
        logic [31:0] a;
        a = {addr[31:2], 2'b00};
        if (model_words.exists(a)) begin
            return model_words[a];
        end
        return fill_word(a);
    endfunction

    // icache never sees data writes, so it expects the old memory words
    function automatic logic [half_bits-1:0] ref_half(input logic [31:0] addr, input logic icache);
        logic [half_bits-1:0] h;
        logic [31:0]          base;
        base = {addr[31:4], 4'b0000};
        for (int k = 0; k < half_bits / 32; k++) begin
            h[k * 32 +: 32] = icache ? fill_word(base + 32'(k * 4)) : ref_word(base + 32'(k * 4));
        end
        return h;
    endfunction

    function automatic logic [line_bits-1:0] ref_line(input logic [31:0] addr);
        logic [line_bits-1:0] l;
        for (int k = 0; k < line_bits / 32; k++) begin
            l[k * 32 +: 32] = ref_word({addr[31:5], 5'b00000} + 32'(k * 4));
        end
        return l;
    endfunction

    function automatic logic [line_bits-1:0] mem_line(input logic [31:0] addr);
        logic [line_bits-1:0] l;
        if (mem_lines.exists(addr)) begin
            return mem_lines[addr];
        end
        for (int k = 0; k < line_bits / 32; k++) begin
            l[k * 32 +: 32] = fill_word(addr + 32'(k * 4));
        end
        return l;
    endfunction

    function automatic logic [31:0] rand_addr(input logic [31:0] base);
        return base + ($urandom_range(7) << 7) + ($urandom_range(3) << 5)
                    + ($urandom_range(7) << 2);
    endfunction

    task automatic model_write(input logic [31:0] addr, input logic [31:0] data,
                               input logic [3:0] strb);
        logic [31:0] w;
        w = ref_word(addr);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                w[b * 8 +: 8] = data[b * 8 +: 8];
            end
        end
        model_words[{addr[31:2], 2'b00}] = w;
    endtask

    task automatic check_half(input string name, input logic [half_bits-1:0] got,
                              input logic [half_bits-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_line(input string name, input logic [line_bits-1:0] got,
                              input logic [line_bits-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input logic [addr_width-1:0] got,
                              input logic [addr_width-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_latency(input string port, input int acc, input int done);
        checks++;
        if (done - acc != 2) begin
            errors++;
            $display("%s hit took %0d cycles from addr_ok to data_ok instead of 2",
                     port, done - acc);
        end
    endtask

    task automatic icache_issue(input logic [31:0] addr);
        exp_ihalf = ref_half(addr, 1'b1);
        i_sent++;
        @(posedge clk);
        #1;
        icache_req  = 1'b1;
        icache_addr = addr;
        @(posedge clk);
        while (!icache_addr_ok) begin
            @(posedge clk);
        end
        i_acc_cycle = cycle;
        cur_addr    = addr;
        #1;
        icache_req = 1'b0;
    endtask

    task automatic dcache_issue(input logic [31:0] addr, input logic wr,
                                input logic [31:0] data, input logic [3:0] strb);
        if (wr) begin
            model_write(addr, data, strb);
        end else begin
            exp_dhalf = ref_half(addr, 1'b0);
        end
        d_write = wr;
        d_sent++;
        @(posedge clk);
        #1;
        dcache_req   = 1'b1;
        dcache_wr    = wr;
        dcache_addr  = addr;
        dcache_wdata = data;
        dcache_wstrb = strb;
        @(posedge clk);
        while (!dcache_addr_ok) begin
            @(posedge clk);
        end
        d_acc_cycle = cycle;
        cur_addr    = addr;
        #1;
        dcache_req = 1'b0;
    endtask

    task automatic wait_done();
        while (i_done != i_sent || d_done != d_sent) begin
            @(posedge clk);
        end
    endtask

    task automatic finish_test(input string name);
        if (errors == test_errors) begin
            $display("test %0d %s: ok", test_no, name);
        end else begin
            $display("test %0d %s: %0d errors", test_no, name, errors - test_errors);
        end
        test_no++;
        test_errors = errors;
    endtask

    initial begin : compare
        forever begin
            @(posedge clk);
            if (icache_data_ok) begin
                check_half("icache_rdata", icache_rdata, exp_ihalf);
                i_done_cycle = cycle;
                i_done++;
            end
            if (dcache_data_ok) begin
                if (!d_write) begin
                    check_half("dcache_rdata", dcache_rdata, exp_dhalf);
                end
                d_done_cycle = cycle;
                d_done++;
            end
        end
    end

    initial begin : mem_read_port
        logic [31:0] a;
        int          delay;
        mem_rd_addr_ok = 1'b0;
        mem_rd_data_ok = 1'b0;
        mem_rd_data    = '0;
        forever begin
            @(posedge clk);
            if (mem_rd_req) begin
                a     = mem_rd_addr;
                // refill fetches the whole line of the request in flight
                check_addr("mem_rd_addr", a, {cur_addr[31:5], 5'b00000});
                delay = $urandom_range(5);
                repeat (delay) @(posedge clk);
                #1;
                mem_rd_addr_ok = 1'b1;
                @(posedge clk);
                #1;
                mem_rd_addr_ok = 1'b0;
                delay = $urandom_range(5);
                repeat (delay) @(posedge clk);
                #1;
                mem_rd_data    = mem_line(a);
                mem_rd_data_ok = 1'b1;
                @(posedge clk);
                #1;
                mem_rd_data_ok = 1'b0;
            end
        end
    end

    initial begin : mem_write_port
        int delay;
        mem_wr_addr_ok = 1'b0;
        forever begin
            @(posedge clk);
            if (mem_wr_req) begin
                delay = $urandom_range(5);
                repeat (delay) @(posedge clk);
                #1;
                mem_wr_addr_ok = 1'b1;
                @(posedge clk);
                // victim line must hold the model's view of that line
                check_line("mem_wr_data", mem_wr_data, ref_line(mem_wr_addr));
                mem_lines[mem_wr_addr] = mem_wr_data;
                last_wr_addr = mem_wr_addr;
                wr_count++;
                #1;
                mem_wr_addr_ok = 1'b0;
            end
        end
    end

    initial begin : main
        int wr_before;
        int kind;
        int assert_fails;
        void'($urandom(32'h9770_0a5a));
        rst          = 1'b1;
        icache_req   = 1'b0;
        icache_addr  = '0;
        dcache_req   = 1'b0;
        dcache_wr    = 1'b0;
        dcache_addr  = '0;
        dcache_wdata = '0;
        dcache_wstrb = '0;
        d_write      = 1'b0;
        cur_addr     = '0;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        icache_issue(ibase + 32'h24);
        wait_done();
        dcache_issue(dbase + 32'h48, 1'b0, 32'h0, 4'h0);
        wait_done();
        finish_test("cold_reads");

        dcache_issue(dbase + 32'h40, 1'b0, 32'h0, 4'h0);
        wait_done();
        check_latency("dcache", d_acc_cycle, d_done_cycle);
        icache_issue(ibase + 32'h30);
        wait_done();
        check_latency("icache", i_acc_cycle, i_done_cycle);
        finish_test("hit_latency");

        dcache_issue(dbase + 32'h0001_0064, 1'b1, $urandom, 4'b0110);
        wait_done();
        dcache_issue(dbase + 32'h0001_0064, 1'b0, 32'h0, 4'h0);
        wait_done();
        icache_issue(dbase + 32'h0001_0064);
        wait_done();
        finish_test("write_merge");

        // A then B fill set 1 and reading A leaves B as the older way
        dcache_issue(dbase + 32'h0002_0020, 1'b1, $urandom, 4'hf);
        wait_done();
        dcache_issue(dbase + 32'h0003_0024, 1'b1, $urandom, 4'b1001);
        wait_done();
        dcache_issue(dbase + 32'h0002_0020, 1'b0, 32'h0, 4'h0);
        wait_done();
        wr_before = wr_count;
        dcache_issue(dbase + 32'h0004_0028, 1'b1, $urandom, 4'hf);
        wait_done();
        checks++;
        if (wr_count - wr_before != 1) begin
            errors++;
            $display("eviction gave %0d writebacks instead of 1", wr_count - wr_before);
        end
        check_addr("mem_wr_addr", last_wr_addr, dbase + 32'h0003_0020);
        finish_test("lru_eviction");

        fork
            icache_issue(ibase + 32'h0001_0010);
            dcache_issue(dbase + 32'h0005_0050, 1'b0, 32'h0, 4'h0);
        join
        wait_done();
        checks++;
        if (d_acc_cycle >= i_acc_cycle) begin
            errors++;
            $display("icache was accepted before the dcache in a same-cycle request");
        end
        finish_test("arbitration");

        for (int n = 0; n < 80; n++) begin
            kind = $urandom_range(2);
            if (kind == 0) begin
                icache_issue(rand_addr(ibase));
            end else begin
                dcache_issue(rand_addr(dbase), kind == 2, $urandom, 4'($urandom_range(1, 15)));
            end
            wait_done();
        end
        finish_test("random_traffic");

        assert_fails = DUT.u_checker.fail_count;
        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
                 test_no - 1, checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
source/l2_geom_pkg.sv
source/l2_ctrl_pkg.sv
source/l2_req_buffer.sv
source/l2_tag_array.sv
source/l2_data_array.sv
source/l2_victim_lru.sv
source/l2_controller.sv
source/l2_cache.sv
test/l2_cache_checker.sv
test/l2_cache_tb.sv

//--- Makefile
TOP = l2_cache_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/10ps -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps -f build.f --top-module $(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
